/* rtl/xbar_defs.svh */
`ifndef XBAR_DEFS_SVH
`define XBAR_DEFS_SVH

// Wishbone word and select widths
`define XBAR_DATA_W 32
`define XBAR_SEL_W 4

// Master address splits into region and offset
`define XBAR_ADDR_W 28
`define XBAR_REGION_W 4
`define XBAR_OFFSET_W 24

// Masters on the crossbar
`define XBAR_MASTERS 2

`endif

/* rtl/wb_bus_pkg.sv */
`include "xbar_defs.svh"

package wb_bus_pkg;

	typedef logic [`XBAR_DATA_W-1:0] wb_data_t;
	typedef logic [`XBAR_SEL_W-1:0] wb_sel_t;
	typedef logic [`XBAR_OFFSET_W-1:0] wb_offset_t;

	// Region selects the slave port, offset goes to the slave
	typedef struct packed {
		logic [`XBAR_REGION_W-1:0] region;
		wb_offset_t offset;
	} wb_addr_fields_t;

	// Master address, raw or split
	typedef union packed {
		logic [`XBAR_ADDR_W-1:0] raw;
		wb_addr_fields_t fields;
	} wb_addr_u;

endpackage

/* rtl/xbar_map_pkg.sv */
`include "xbar_defs.svh"

package xbar_map_pkg;

	// Region codes of the slave ports
	localparam logic [`XBAR_REGION_W-1:0] REGION_S0 = 4'h0;
	localparam logic [`XBAR_REGION_W-1:0] REGION_S1 = 4'h1;

	// Master index, as shown on the probes
	typedef logic [$clog2(`XBAR_MASTERS)-1:0] master_idx_t;

endpackage

/* rtl/wb_master_port.sv */
`timescale 1ns/100ps
`include "xbar_defs.svh"

module wb_master_port (
	input logic cyc_i,
	input wb_bus_pkg::wb_addr_u adr_i,

	// Slave 0 side
	output logic s0_cyc_o,
	input logic s0_ack_i,
	input logic s0_stall_i,
	input logic s0_err_i,
	input wb_bus_pkg::wb_data_t s0_data_i,

	// Slave 1 side
	output logic s1_cyc_o,
	input logic s1_ack_i,
	input logic s1_stall_i,
	input logic s1_err_i,
	input wb_bus_pkg::wb_data_t s1_data_i,

	// Response to the master
	output logic ack_o,
	output logic stall_o,
	output logic err_o,
	output wb_bus_pkg::wb_data_t data_o
);

	import wb_bus_pkg::*;
	import xbar_map_pkg::*;

	localparam wb_data_t UNMAPPED_DATA = '0;

	logic sel_s0;
	logic sel_s1;

	assign sel_s0 = (adr_i.fields.region == REGION_S0);
	assign sel_s1 = (adr_i.fields.region == REGION_S1);

	// Cycle only reaches the addressed slave
	assign s0_cyc_o = cyc_i && sel_s0;
	assign s1_cyc_o = cyc_i && sel_s1;

	always_comb begin
		if (sel_s0) begin
			ack_o = s0_ack_i;
			stall_o = s0_stall_i;
			err_o = s0_err_i;
			data_o = s0_data_i;
		end else if (sel_s1) begin
			ack_o = s1_ack_i;
			stall_o = s1_stall_i;
			err_o = s1_err_i;
			data_o = s1_data_i;
		end else begin
			// No slave here, acked at once with zero data
			ack_o = cyc_i;
			stall_o = 1'b0;
			err_o = 1'b0;
			data_o = UNMAPPED_DATA;
		end
	end

	always_comb begin
		a_one_slave: assert ($onehot0({s0_cyc_o, s1_cyc_o}))
			else $error("master port drives cyc to both slaves");
	end

endmodule

/* rtl/wb_slave_arbiter.sv */
`timescale 1ns/100ps
`include "xbar_defs.svh"

module wb_slave_arbiter (
	input logic wb_clk_i,
	input logic rst_i,

	// Master 0 request and response
	input logic m0_cyc_i,
	input logic m0_stb_i,
	input logic m0_we_i,
	input wb_bus_pkg::wb_sel_t m0_sel_i,
	input wb_bus_pkg::wb_data_t m0_data_i,
	input wb_bus_pkg::wb_offset_t m0_adr_i,
	output logic m0_ack_o,
	output logic m0_stall_o,
	output logic m0_err_o,
	output wb_bus_pkg::wb_data_t m0_data_o,

	// Master 1 request and response
	input logic m1_cyc_i,
	input logic m1_stb_i,
	input logic m1_we_i,
	input wb_bus_pkg::wb_sel_t m1_sel_i,
	input wb_bus_pkg::wb_data_t m1_data_i,
	input wb_bus_pkg::wb_offset_t m1_adr_i,
	output logic m1_ack_o,
	output logic m1_stall_o,
	output logic m1_err_o,
	output wb_bus_pkg::wb_data_t m1_data_o,

	// Slave side
	output logic slv_cyc_o,
	output logic slv_stb_o,
	output logic slv_we_o,
	output wb_bus_pkg::wb_sel_t slv_sel_o,
	output wb_bus_pkg::wb_data_t slv_data_o,
	output wb_bus_pkg::wb_offset_t slv_adr_o,
	input logic slv_ack_i,
	input logic slv_stall_i,
	input logic slv_err_i,
	input wb_bus_pkg::wb_data_t slv_data_i,

	output xbar_map_pkg::master_idx_t cur_master_o
);

	import wb_bus_pkg::*;
	import xbar_map_pkg::*;

	localparam wb_data_t IDLE_DATA = '0;

	logic locked_q;
	master_idx_t grant_q;
	logic grant_cyc;
	logic free;
	master_idx_t prio_idx;
	master_idx_t act_idx;
	logic own_m0;
	logic own_m1;

	// Lock is released as soon as the holder drops cyc
	assign grant_cyc = grant_q ? m1_cyc_i : m0_cyc_i;
	assign free = !locked_q || !grant_cyc;

	// Fixed priority, master 0 first
	assign prio_idx = master_idx_t'(!m0_cyc_i);
	assign act_idx = free ? prio_idx : grant_q;

	always_ff @(posedge wb_clk_i) begin
		if (rst_i) begin
			locked_q <= 1'b0;
			grant_q <= '0;
		end else if (free) begin
			locked_q <= m0_cyc_i || m1_cyc_i;
			if (m0_cyc_i || m1_cyc_i)
				grant_q <= prio_idx;
		end
	end

	assign cur_master_o = grant_q;

	assign own_m0 = m0_cyc_i && !act_idx;
	assign own_m1 = m1_cyc_i && act_idx;

	// Request mux towards the slave
	assign slv_cyc_o = own_m0 || own_m1;
	assign slv_stb_o = own_m1 ? m1_stb_i : (own_m0 && m0_stb_i);
	assign slv_we_o = act_idx ? m1_we_i : m0_we_i;
	assign slv_sel_o = act_idx ? m1_sel_i : m0_sel_i;
	assign slv_data_o = act_idx ? m1_data_i : m0_data_i;
	assign slv_adr_o = act_idx ? m1_adr_i : m0_adr_i;

	// Losing master is held off with stall
	assign m0_ack_o = own_m0 && slv_ack_i;
	assign m0_err_o = own_m0 && slv_err_i;
	assign m0_stall_o = own_m0 ? slv_stall_i : m0_cyc_i;
	assign m0_data_o = own_m0 ? slv_data_i : IDLE_DATA;

	assign m1_ack_o = own_m1 && slv_ack_i;
	assign m1_err_o = own_m1 && slv_err_i;
	assign m1_stall_o = own_m1 ? slv_stall_i : m1_cyc_i;
	assign m1_data_o = own_m1 ? slv_data_i : IDLE_DATA;

	// Slave cycle always belongs to a live master cycle
	a_slv_cyc_owner: assert property (@(posedge wb_clk_i) disable iff (rst_i)
		slv_cyc_o |-> (act_idx ? m1_cyc_i : m0_cyc_i));

	// Grant stays put while the holder keeps cyc high
	a_grant_held: assert property (@(posedge wb_clk_i) disable iff (rst_i)
		($past(slv_cyc_o) && ($past(act_idx) ? m1_cyc_i : m0_cyc_i))
		|-> act_idx == $past(act_idx));

	a_no_ack_loser: assert property (@(posedge wb_clk_i) disable iff (rst_i)
		(m0_cyc_i && m1_cyc_i) |-> !(act_idx ? m0_ack_o : m1_ack_o));

endmodule

/* rtl/wb_xbar_top.sv */
`timescale 1ns/100ps
`include "xbar_defs.svh"

module wb_xbar_top (
	input logic wb_clk_i,
	input logic rst_i,

	// Master 0
	input logic m0_cyc_i,
	input logic m0_stb_i,
	input logic m0_we_i,
	input wb_bus_pkg::wb_sel_t m0_sel_i,
	input wb_bus_pkg::wb_data_t m0_data_i,
	input wb_bus_pkg::wb_addr_u m0_adr_i,
	output logic m0_ack_o,
	output logic m0_stall_o,
	output logic m0_err_o,
	output wb_bus_pkg::wb_data_t m0_data_o,

	// Master 1
	input logic m1_cyc_i,
	input logic m1_stb_i,
	input logic m1_we_i,
	input wb_bus_pkg::wb_sel_t m1_sel_i,
	input wb_bus_pkg::wb_data_t m1_data_i,
	input wb_bus_pkg::wb_addr_u m1_adr_i,
	output logic m1_ack_o,
	output logic m1_stall_o,
	output logic m1_err_o,
	output wb_bus_pkg::wb_data_t m1_data_o,

	// Slave 0
	output logic s0_cyc_o,
	output logic s0_stb_o,
	output logic s0_we_o,
	output wb_bus_pkg::wb_sel_t s0_sel_o,
	output wb_bus_pkg::wb_data_t s0_data_o,
	output wb_bus_pkg::wb_offset_t s0_adr_o,
	input logic s0_ack_i,
	input logic s0_stall_i,
	input logic s0_err_i,
	input wb_bus_pkg::wb_data_t s0_data_i,

	// Slave 1
	output logic s1_cyc_o,
	output logic s1_stb_o,
	output logic s1_we_o,
	output wb_bus_pkg::wb_sel_t s1_sel_o,
	output wb_bus_pkg::wb_data_t s1_data_o,
	output wb_bus_pkg::wb_offset_t s1_adr_o,
	input logic s1_ack_i,
	input logic s1_stall_i,
	input logic s1_err_i,
	input wb_bus_pkg::wb_data_t s1_data_i,

	output xbar_map_pkg::master_idx_t s0_cur_master_o,
	output xbar_map_pkg::master_idx_t s1_cur_master_o
);

	import wb_bus_pkg::*;

	// Gated cycles, named master then slave
	logic m0_s0_cyc;
	logic m0_s1_cyc;
	logic m1_s0_cyc;
	logic m1_s1_cyc;

	// Responses from each arbiter to each master port
	logic m0_s0_ack;
	logic m0_s0_stall;
	logic m0_s0_err;
	wb_data_t m0_s0_data;
	logic m0_s1_ack;
	logic m0_s1_stall;
	logic m0_s1_err;
	wb_data_t m0_s1_data;
	logic m1_s0_ack;
	logic m1_s0_stall;
	logic m1_s0_err;
	wb_data_t m1_s0_data;
	logic m1_s1_ack;
	logic m1_s1_stall;
	logic m1_s1_err;
	wb_data_t m1_s1_data;

	wb_master_port u_mport0 (
		.cyc_i(m0_cyc_i), .adr_i(m0_adr_i),
		.s0_cyc_o(m0_s0_cyc), .s0_ack_i(m0_s0_ack), .s0_stall_i(m0_s0_stall),
		.s0_err_i(m0_s0_err), .s0_data_i(m0_s0_data),
		.s1_cyc_o(m0_s1_cyc), .s1_ack_i(m0_s1_ack), .s1_stall_i(m0_s1_stall),
		.s1_err_i(m0_s1_err), .s1_data_i(m0_s1_data),
		.ack_o(m0_ack_o), .stall_o(m0_stall_o), .err_o(m0_err_o), .data_o(m0_data_o)
	);

	wb_master_port u_mport1 (
		.cyc_i(m1_cyc_i), .adr_i(m1_adr_i),
		.s0_cyc_o(m1_s0_cyc), .s0_ack_i(m1_s0_ack), .s0_stall_i(m1_s0_stall),
		.s0_err_i(m1_s0_err), .s0_data_i(m1_s0_data),
		.s1_cyc_o(m1_s1_cyc), .s1_ack_i(m1_s1_ack), .s1_stall_i(m1_s1_stall),
		.s1_err_i(m1_s1_err), .s1_data_i(m1_s1_data),
		.ack_o(m1_ack_o), .stall_o(m1_stall_o), .err_o(m1_err_o), .data_o(m1_data_o)
	);

	wb_slave_arbiter u_sarb0 (
		.wb_clk_i(wb_clk_i), .rst_i(rst_i),
		.m0_cyc_i(m0_s0_cyc), .m0_stb_i(m0_stb_i), .m0_we_i(m0_we_i),
		.m0_sel_i(m0_sel_i), .m0_data_i(m0_data_i), .m0_adr_i(m0_adr_i.fields.offset),
		.m0_ack_o(m0_s0_ack), .m0_stall_o(m0_s0_stall), .m0_err_o(m0_s0_err),
		.m0_data_o(m0_s0_data),
		.m1_cyc_i(m1_s0_cyc), .m1_stb_i(m1_stb_i), .m1_we_i(m1_we_i),
		.m1_sel_i(m1_sel_i), .m1_data_i(m1_data_i), .m1_adr_i(m1_adr_i.fields.offset),
		.m1_ack_o(m1_s0_ack), .m1_stall_o(m1_s0_stall), .m1_err_o(m1_s0_err),
		.m1_data_o(m1_s0_data),
		.slv_cyc_o(s0_cyc_o), .slv_stb_o(s0_stb_o), .slv_we_o(s0_we_o),
		.slv_sel_o(s0_sel_o), .slv_data_o(s0_data_o), .slv_adr_o(s0_adr_o),
		.slv_ack_i(s0_ack_i), .slv_stall_i(s0_stall_i), .slv_err_i(s0_err_i),
		.slv_data_i(s0_data_i),
		.cur_master_o(s0_cur_master_o)
	);

	wb_slave_arbiter u_sarb1 (
		.wb_clk_i(wb_clk_i), .rst_i(rst_i),
		.m0_cyc_i(m0_s1_cyc), .m0_stb_i(m0_stb_i), .m0_we_i(m0_we_i),
		.m0_sel_i(m0_sel_i), .m0_data_i(m0_data_i), .m0_adr_i(m0_adr_i.fields.offset),
		.m0_ack_o(m0_s1_ack), .m0_stall_o(m0_s1_stall), .m0_err_o(m0_s1_err),
		.m0_data_o(m0_s1_data),
		.m1_cyc_i(m1_s1_cyc), .m1_stb_i(m1_stb_i), .m1_we_i(m1_we_i),
		.m1_sel_i(m1_sel_i), .m1_data_i(m1_data_i), .m1_adr_i(m1_adr_i.fields.offset),
		.m1_ack_o(m1_s1_ack), .m1_stall_o(m1_s1_stall), .m1_err_o(m1_s1_err),
		.m1_data_o(m1_s1_data),
		.slv_cyc_o(s1_cyc_o), .slv_stb_o(s1_stb_o), .slv_we_o(s1_we_o),
		.slv_sel_o(s1_sel_o), .slv_data_o(s1_data_o), .slv_adr_o(s1_adr_o),
		.slv_ack_i(s1_ack_i), .slv_stall_i(s1_stall_i), .slv_err_i(s1_err_i),
		.slv_data_i(s1_data_i),
		.cur_master_o(s1_cur_master_o)
	);

endmodule

/* test/tb_slave_mem.sv */
`timescale 1ns/100ps
`include "xbar_defs.svh"

module tb_slave_mem (
	input logic clk_i,
	input logic rst_i,
	input logic cyc_i,
	input logic stb_i,
	input logic we_i,
	input wb_bus_pkg::wb_sel_t sel_i,
	input wb_bus_pkg::wb_data_t data_i,
	input wb_bus_pkg::wb_offset_t adr_i,
	// Stall request from the testbench
	input logic hold_i,
	output logic ack_o,
	output logic stall_o,
	output logic err_o,
	output wb_bus_pkg::wb_data_t data_o
);

	import wb_bus_pkg::*;

	localparam int DEPTH = 16;

	wb_data_t mem [DEPTH];
	wb_data_t byte_mask;
	logic [$clog2(DEPTH)-1:0] idx;

	assign stall_o = hold_i;
	assign idx = adr_i[$clog2(DEPTH)-1:0];
	assign byte_mask = {{8{sel_i[3]}}, {8{sel_i[2]}}, {8{sel_i[1]}}, {8{sel_i[0]}}};

	// One response per accepted request, one cycle later
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			ack_o <= 1'b0;
			err_o <= 1'b0;
			data_o <= '0;
		end else begin
			ack_o <= 1'b0;
			err_o <= 1'b0;
			if (cyc_i && stb_i && !hold_i) begin
				if (adr_i[`XBAR_OFFSET_W-1]) begin
					// Top offset bit marks a faulting address
					err_o <= 1'b1;
				end else begin
					ack_o <= 1'b1;
					data_o <= mem[idx];
					if (we_i)
						mem[idx] <= (mem[idx] & ~byte_mask) | (data_i & byte_mask);
				end
			end
		end
	end

endmodule

/* test/tb_wb_xbar.sv */
`timescale 1ns/100ps
`include "xbar_defs.svh"

module tb_wb_xbar;

	import wb_bus_pkg::*;
	import xbar_map_pkg::*;

	localparam int PERIOD_NS = 4;
	localparam int ACCESS_LIMIT = 20;
	localparam int ACCESSES = 15;
	localparam int STALL_CYCLES = 3;
	localparam int WATCHDOG_NS = (ACCESSES * (ACCESS_LIMIT + 2) + 3) * PERIOD_NS + 100;
	localparam logic [31:0] SEED = 32'h881ff98f;
	localparam logic [`XBAR_REGION_W-1:0] REGION_NONE = 4'h7;

	logic clk = 1'b0;
	logic rst = 1'b1;
	logic [31:0] lfsr = SEED;
	int checks = 0;
	int errors = 0;

	// Master side, index is the master
	logic cyc [2] = '{default: 1'b0};
	logic stb [2] = '{default: 1'b0};
	logic we [2] = '{default: 1'b0};
	wb_sel_t sel [2] = '{default: '0};
	wb_data_t wdat [2] = '{default: '0};
	wb_addr_u adr [2] = '{default: '0};
	logic ack [2];
	logic stall [2];
	logic err [2];
	wb_data_t rdat [2];

	// Slave side, index is the slave
	logic s_cyc [2];
	logic s_stb [2];
	logic s_we [2];
	wb_sel_t s_sel [2];
	wb_data_t s_wdat [2];
	wb_offset_t s_adr [2];
	logic s_ack [2];
	logic s_stall [2];
	logic s_err [2];
	wb_data_t s_rdat [2];
	logic hold [2] = '{default: 1'b0};
	master_idx_t probe [2];

	always #(PERIOD_NS / 2) clk = ~clk;

	wb_xbar_top dut_i (
		.wb_clk_i(clk), .rst_i(rst),
		.m0_cyc_i(cyc[0]), .m0_stb_i(stb[0]), .m0_we_i(we[0]), .m0_sel_i(sel[0]),
		.m0_data_i(wdat[0]), .m0_adr_i(adr[0]), .m0_ack_o(ack[0]), .m0_stall_o(stall[0]),
		.m0_err_o(err[0]), .m0_data_o(rdat[0]),
		.m1_cyc_i(cyc[1]), .m1_stb_i(stb[1]), .m1_we_i(we[1]), .m1_sel_i(sel[1]),
		.m1_data_i(wdat[1]), .m1_adr_i(adr[1]), .m1_ack_o(ack[1]), .m1_stall_o(stall[1]),
		.m1_err_o(err[1]), .m1_data_o(rdat[1]),
		.s0_cyc_o(s_cyc[0]), .s0_stb_o(s_stb[0]), .s0_we_o(s_we[0]), .s0_sel_o(s_sel[0]),
		.s0_data_o(s_wdat[0]), .s0_adr_o(s_adr[0]), .s0_ack_i(s_ack[0]),
		.s0_stall_i(s_stall[0]), .s0_err_i(s_err[0]), .s0_data_i(s_rdat[0]),
		.s1_cyc_o(s_cyc[1]), .s1_stb_o(s_stb[1]), .s1_we_o(s_we[1]), .s1_sel_o(s_sel[1]),
		.s1_data_o(s_wdat[1]), .s1_adr_o(s_adr[1]), .s1_ack_i(s_ack[1]),
		.s1_stall_i(s_stall[1]), .s1_err_i(s_err[1]), .s1_data_i(s_rdat[1]),
		.s0_cur_master_o(probe[0]), .s1_cur_master_o(probe[1])
	);

	tb_slave_mem mem0 (
		.clk_i(clk), .rst_i(rst), .cyc_i(s_cyc[0]), .stb_i(s_stb[0]), .we_i(s_we[0]),
		.sel_i(s_sel[0]), .data_i(s_wdat[0]), .adr_i(s_adr[0]), .hold_i(hold[0]),
		.ack_o(s_ack[0]), .stall_o(s_stall[0]), .err_o(s_err[0]), .data_o(s_rdat[0])
	);

	tb_slave_mem mem1 (
		.clk_i(clk), .rst_i(rst), .cyc_i(s_cyc[1]), .stb_i(s_stb[1]), .we_i(s_we[1]),
		.sel_i(s_sel[1]), .data_i(s_wdat[1]), .adr_i(s_adr[1]), .hold_i(hold[1]),
		.ack_o(s_ack[1]), .stall_o(s_stall[1]), .err_o(s_err[1]), .data_o(s_rdat[1])
	);

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic wb_data_t rand_word();
		wb_data_t w;
		w = '0;
		repeat (`XBAR_DATA_W) begin
			lfsr = lfsr_step(lfsr);
			w = {w[`XBAR_DATA_W-2:0], lfsr[0]};
		end
		return w;
	endfunction

	task automatic compare(input string name, input wb_data_t got, input wb_data_t exp);
		checks++;
		if (got !== exp) begin
			$display("error %s: got %h, expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic report_test(input string name, input int mark);
		$display("test %s: %s", name, (errors == mark) ? "passed" : "failed");
	endtask

	// One request on master m, waits for its ack or error
	task automatic wb_access(input master_idx_t m, input logic [`XBAR_ADDR_W-1:0] a,
			input logic w, input wb_data_t wd, output wb_data_t rd,
			output logic got_ack, output logic got_err, output int cycles);
		logic accepted;
		accepted = 1'b0;
		got_ack = 1'b0;
		got_err = 1'b0;
		rd = '0;
		cycles = 0;
		@(negedge clk);
		cyc[m] = 1'b1;
		stb[m] = 1'b1;
		we[m] = w;
		sel[m] = '1;
		wdat[m] = wd;
		adr[m].raw = a;
		while (!got_ack && !got_err && cycles < ACCESS_LIMIT) begin
			// Values as the next rising edge sees them
			#1;
			cycles++;
			got_ack = ack[m];
			got_err = err[m];
			rd = rdat[m];
			if (stb[m] && !stall[m])
				accepted = 1'b1;
			@(negedge clk);
			if (accepted)
				stb[m] = 1'b0;
		end
		if (!got_ack && !got_err) begin
			$display("master %0d got no response within %0d cycles", m, ACCESS_LIMIT);
			errors++;
		end
		cyc[m] = 1'b0;
		stb[m] = 1'b0;
	endtask

	task automatic m0_round_trip();
		wb_data_t w0;
		wb_data_t w1;
		wb_data_t rd;
		logic a;
		logic e;
		int n;
		w0 = rand_word();
		w1 = rand_word();
		wb_access(1'b0, {REGION_S0, 24'h000005}, 1'b1, w0, rd, a, e, n);
		compare("s0_cur_master_o", 32'(probe[0]), 32'd0);
		wb_access(1'b0, {REGION_S1, 24'h000005}, 1'b1, w1, rd, a, e, n);
		compare("s1_cur_master_o", 32'(probe[1]), 32'd0);
		wb_access(1'b0, {REGION_S0, 24'h000005}, 1'b0, '0, rd, a, e, n);
		compare("m0_data_o", rd, w0);
		wb_access(1'b0, {REGION_S1, 24'h000005}, 1'b0, '0, rd, a, e, n);
		compare("m0_data_o", rd, w1);
	endtask

	task automatic m1_write_m0_read();
		wb_data_t w;
		wb_data_t rd;
		logic a;
		logic e;
		int n;
		w = rand_word();
		wb_access(1'b1, {REGION_S1, 24'h00000a}, 1'b1, w, rd, a, e, n);
		compare("m1_ack_o", 32'(a), 32'd1);
		compare("m1_err_o", 32'(e), 32'd0);
		compare("s1_cur_master_o", 32'(probe[1]), 32'd1);
		wb_access(1'b0, {REGION_S1, 24'h00000a}, 1'b0, '0, rd, a, e, n);
		compare("m0_data_o", rd, w);
	endtask

	task automatic unmapped_and_error();
		wb_data_t rd;
		logic a;
		logic e;
		int n;
		wb_access(1'b0, {REGION_NONE, 24'h000010}, 1'b0, '0, rd, a, e, n);
		compare("m0_ack_o", 32'(a), 32'd1);
		compare("m0_ack_o cycles", 32'(n), 32'd1);
		compare("m0_err_o", 32'(e), 32'd0);
		compare("m0_data_o", rd, '0);
		wb_access(1'b0, {REGION_S0, 24'h800003}, 1'b0, '0, rd, a, e, n);
		compare("m0_err_o", 32'(e), 32'd1);
		compare("m0_ack_o", 32'(a), 32'd0);
	endtask

	task automatic slave0_contention();
		wb_data_t w;
		wb_data_t rd0;
		wb_data_t rd1;
		logic a0;
		logic a1;
		logic e0;
		logic e1;
		int n0;
		int n1;
		w = rand_word();
		fork
			begin
				wb_access(1'b0, {REGION_S0, 24'h000007}, 1'b1, w, rd0, a0, e0, n0);
				compare("s0_cur_master_o", 32'(probe[0]), 32'd0);
			end
			wb_access(1'b1, {REGION_S0, 24'h000007}, 1'b0, '0, rd1, a1, e1, n1);
		join
		// Master 1 only reaches the slave after master 0 is done
		compare("m1_stall_o", 32'(n1 > n0), 32'd1);
		compare("m1_data_o", rd1, w);
		compare("s0_cur_master_o", 32'(probe[0]), 32'd1);
	endtask

	task automatic parallel_and_stall();
		wb_data_t w0;
		wb_data_t w1;
		wb_data_t rd0;
		wb_data_t rd1;
		logic a0;
		logic a1;
		logic e0;
		logic e1;
		int n0;
		int n1;
		w0 = rand_word();
		w1 = rand_word();
		fork
			wb_access(1'b0, {REGION_S0, 24'h000002}, 1'b1, w0, rd0, a0, e0, n0);
			wb_access(1'b1, {REGION_S1, 24'h000002}, 1'b1, w1, rd1, a1, e1, n1);
		join
		fork
			wb_access(1'b0, {REGION_S0, 24'h000002}, 1'b0, '0, rd0, a0, e0, n0);
			wb_access(1'b1, {REGION_S1, 24'h000002}, 1'b0, '0, rd1, a1, e1, n1);
		join
		compare("m0_data_o", rd0, w0);
		compare("m1_data_o", rd1, w1);
		hold[0] = 1'b1;
		fork
			wb_access(1'b0, {REGION_S0, 24'h000002}, 1'b0, '0, rd0, a0, e0, n0);
			begin
				repeat (STALL_CYCLES) @(negedge clk);
				hold[0] = 1'b0;
			end
		join
		compare("m0_stall_o", 32'(n0 > 2), 32'd1);
		compare("m0_data_o", rd0, w0);
	endtask

	initial begin
		int mark;
		repeat (3) @(negedge clk);
		rst = 1'b0;
		mark = errors;
		m0_round_trip();
		report_test("master 0 routing", mark);
		mark = errors;
		m1_write_m0_read();
		report_test("master 1 routing", mark);
		mark = errors;
		unmapped_and_error();
		report_test("unmapped region and error", mark);
		mark = errors;
		slave0_contention();
		report_test("contention on slave 0", mark);
		mark = errors;
		parallel_and_stall();
		report_test("parallel and back-pressure", mark);
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired before the tests finished");
		$display("ERRORS FOUND");
		$finish;
	end

endmodule

/* wb_xbar.f */
+incdir+rtl
rtl/wb_bus_pkg.sv
rtl/xbar_map_pkg.sv
rtl/wb_master_port.sv
rtl/wb_slave_arbiter.sv
rtl/wb_xbar_top.sv
test/tb_slave_mem.sv
test/tb_wb_xbar.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the crossbar testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
	-f wb_xbar.f --top-module tb_wb_xbar -o tb_wb_xbar

./obj_dir/tb_wb_xbar > sim.log
cat sim.log

if grep -q "ERRORS FOUND" sim.log; then
	exit 1
fi
